/* src/shift_pkg.sv */
package shift_pkg;

  // Lane count, must be a power of two so the pointers wrap naturally
  localparam int n_lanes = 4;
  localparam int lane_idx_w = (n_lanes > 1) ? $clog2(n_lanes) : 1;

  // Lane phase codes
  localparam logic [1:0] phase_idle    = 2'd0;
  localparam logic [1:0] phase_latched = 2'd1;
  localparam logic [1:0] phase_done    = 2'd2;

  // Collector output phase codes
  localparam logic [1:0] coll_idle    = 2'd0;
  localparam logic [1:0] coll_req     = 2'd1;
  localparam logic [1:0] coll_release = 2'd2;

  // ARM shift type encoding
  typedef enum logic [1:0] {
    shift_lsl = 2'd0,
    shift_lsr = 2'd1,
    shift_asr = 2'd2,
    shift_ror = 2'd3
  } shift_type_t;

  // Operand 2, shift by immediate amount
  typedef struct packed {
    logic [4:0]  amount;
    shift_type_t shift_type;
    logic        form;
    logic [3:0]  rm_idx;
  } op2_imm_t;

  // Operand 2, shift by Rs
  typedef struct packed {
    logic [3:0]  rs_idx;
    logic        zero;
    shift_type_t shift_type;
    logic        form;
    logic [3:0]  rm_idx;
  } op2_reg_t;

  // Bit 4 tells which view applies
  typedef union packed {
    op2_imm_t imm;
    op2_reg_t regs;
  } op2_t;

endpackage

/* src/barrel_shifter_lane.sv */
`timescale 1ns/10ps

module barrel_shifter_lane import shift_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         start,
  input  shift_type_t  shift_type,
  input  logic [4:0]   amount,
  input  logic         use_reg,
  input  logic [31:0]  rm,
  input  logic [7:0]   rs_byte,
  input  logic         carry_in,
  input  logic         take,
  output logic         busy,
  output logic         done,
  output logic [31:0]  result,
  output logic         carry_out
);

  logic [1:0]   phase;

  // Register form operands held for the second cycle
  // Full byte is kept since amounts above 31 still matter
  logic [7:0]   amt_reg;
  logic [31:0]  rm_q;
  shift_type_t  type_q;
  logic         cin_q;

  logic         from_latch;
  logic [31:0]  sh_rm;
  shift_type_t  sh_type;
  logic         sh_cin;
  logic [7:0]   amt_full;
  logic [4:0]   amt_5;
  logic [4:0]   lsl_idx;
  logic [4:0]   rsh_idx;
  logic [63:0]  ror_full;
  logic [31:0]  sh_result;
  logic         sh_carry;
  logic         load_result;

  assign busy = (phase != phase_idle);
  assign done = (phase == phase_done);

  // Operand select, latched copy in the second cycle of a register shift
  assign from_latch = (phase == phase_latched);
  assign sh_rm      = from_latch ? rm_q : rm;
  assign sh_type    = from_latch ? type_q : shift_type;
  assign sh_cin     = from_latch ? cin_q : carry_in;
  assign amt_full   = from_latch ? amt_reg : {3'b000, amount};
  assign amt_5      = amt_full[4:0];

  // Carry bit positions, valid for amounts 1 to 31
  assign lsl_idx  = 5'd0 - amt_5;
  assign rsh_idx  = amt_5 - 5'd1;
  assign ror_full = {sh_rm, sh_rm} >> amt_5;

  always_comb begin
    sh_result = sh_rm;
    sh_carry  = sh_cin;
    case (sh_type)
      shift_lsl: begin
        if (amt_full == 8'd0) begin
          sh_result = sh_rm;
          sh_carry  = sh_cin;
        end else if (amt_full < 8'd32) begin
          sh_result = sh_rm << amt_5;
          sh_carry  = sh_rm[lsl_idx];
        end else if (amt_full == 8'd32) begin
          sh_result = 32'd0;
          sh_carry  = sh_rm[0];
        end else begin
          sh_result = 32'd0;
          sh_carry  = 1'b0;
        end
      end
      shift_lsr: begin
        if (amt_full == 8'd0 && !from_latch) begin
          // Immediate LSR #0 encodes LSR #32
          sh_result = 32'd0;
          sh_carry  = sh_rm[31];
        end else if (amt_full == 8'd0) begin
          sh_result = sh_rm;
          sh_carry  = sh_cin;
        end else if (amt_full < 8'd32) begin
          sh_result = sh_rm >> amt_5;
          sh_carry  = sh_rm[rsh_idx];
        end else if (amt_full == 8'd32) begin
          sh_result = 32'd0;
          sh_carry  = sh_rm[31];
        end else begin
          sh_result = 32'd0;
          sh_carry  = 1'b0;
        end
      end
      shift_asr: begin
        if (amt_full == 8'd0 && from_latch) begin
          sh_result = sh_rm;
          sh_carry  = sh_cin;
        end else if (amt_full != 8'd0 && amt_full < 8'd32) begin
          sh_result = $signed(sh_rm) >>> amt_5;
          sh_carry  = sh_rm[rsh_idx];
        end else begin
          // Immediate ASR #0 and anything from 32 up give the sign fill
          sh_result = {32{sh_rm[31]}};
          sh_carry  = sh_rm[31];
        end
      end
      shift_ror: begin
        if (amt_full == 8'd0) begin
          sh_result = sh_rm;
          sh_carry  = sh_cin;
        end else if (amt_5 == 5'd0) begin
          // Nonzero multiple of 32
          sh_result = sh_rm;
          sh_carry  = sh_rm[31];
        end else begin
          sh_result = ror_full[31:0];
          sh_carry  = sh_rm[rsh_idx];
        end
      end
      default: begin
        sh_result = sh_rm;
        sh_carry  = sh_cin;
      end
    endcase
  end

  assign load_result = (phase == phase_idle && start && !use_reg) || from_latch;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= phase_idle;
    end else begin
      case (phase)
        phase_idle: begin
          if (start) begin
            phase <= use_reg ? phase_latched : phase_done;
          end
        end
        phase_latched: phase <= phase_done;
        phase_done: begin
          if (take) begin
            phase <= phase_idle;
          end
        end
        default: phase <= phase_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase == phase_idle && start) begin
      amt_reg <= rs_byte;
      rm_q    <= rm;
      type_q  <= shift_type;
      cin_q   <= carry_in;
    end
    if (load_result) begin
      result    <= sh_result;
      carry_out <= sh_carry;
    end
  end

endmodule

/* src/shift_dispatch.sv */
`timescale 1ns/10ps

module shift_dispatch import shift_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_req,
  input  op2_t                op2,
  input  logic [31:0]         rm_value,
  input  logic [31:0]         rs_value,
  input  logic                carry_in,
  input  logic [n_lanes-1:0]  lane_busy,
  output logic                in_ack,
  output logic [n_lanes-1:0]  lane_start,
  output shift_type_t         shared_type,
  output logic [4:0]          shared_amount,
  output logic                shared_use_reg,
  output logic [31:0]         shared_rm,
  output logic [7:0]          shared_rs_byte,
  output logic                shared_carry
);

  // Next lane to receive a job
  logic [lane_idx_w-1:0] ptr;
  logic                  accept;
  logic                  use_reg;

  // A new request is only taken once the previous ack has dropped
  assign accept = in_req && !in_ack && !lane_busy[ptr];

  // Form bit sits at the same position in both views
  assign use_reg = op2.regs.form;

  // Operand 2 decode
  always_comb begin
    // Type field sits at the same bits in both views
    shared_type = op2.imm.shift_type;
    if (use_reg) begin
      // Amount comes from Rs and the lane latches it
      shared_amount = 5'd0;
    end else begin
      shared_amount = op2.imm.amount;
    end
  end

  assign shared_use_reg = use_reg;
  assign shared_rm      = rm_value;
  assign shared_rs_byte = rs_value[7:0];
  assign shared_carry   = carry_in;

  // One-hot start pulse to the pointer lane
  always_comb begin
    lane_start = '0;
    if (accept) begin
      lane_start[ptr] = 1'b1;
    end
  end

  // Round-robin issue pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (accept) begin
      ptr <= ptr + 1'b1;
    end
  end

  // Input four-phase handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      in_ack <= 1'b0;
    end else if (accept) begin
      in_ack <= 1'b1;
    end else if (in_ack && !in_req) begin
      // Requester has released req
      in_ack <= 1'b0;
    end
  end

endmodule

/* src/shift_collector.sv */
`timescale 1ns/10ps

module shift_collector import shift_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic [n_lanes-1:0]  lane_done,
  input  logic [31:0]         lane_result [n_lanes],
  input  logic [n_lanes-1:0]  lane_carry,
  input  logic                out_ack,
  output logic [n_lanes-1:0]  lane_take,
  output logic                out_req,
  output logic [31:0]         result,
  output logic                carry_out
);

  // Follows the dispatcher's issue order, so no tags are needed
  logic [lane_idx_w-1:0] ptr;
  logic [1:0]            state;
  logic                  grab;

  // Oldest lane has finished and the output side is free
  assign grab = (state == coll_idle) && lane_done[ptr];

  always_comb begin
    lane_take = '0;
    if (grab) begin
      lane_take[ptr] = 1'b1;
    end
  end

  assign out_req = (state == coll_req);

  // Output four-phase handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= coll_idle;
      ptr   <= '0;
    end else begin
      case (state)
        coll_idle: begin
          if (grab) begin
            state <= coll_req;
          end
        end
        coll_req: begin
          if (out_ack) begin
            state <= coll_release;
          end
        end
        coll_release: begin
          // Ack dropped, move on to the next lane in order
          if (!out_ack) begin
            state <= coll_idle;
            ptr   <= ptr + 1'b1;
          end
        end
        default: state <= coll_idle;
      endcase
    end
  end

  // Output data register, stable for the whole req phase
  always_ff @(posedge clk) begin
    if (grab) begin
      result    <= lane_result[ptr];
      carry_out <= lane_carry[ptr];
    end
  end

endmodule

/* src/shift_engine.sv */
`timescale 1ns/10ps

module shift_engine import shift_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         in_req,
  input  op2_t         op2,
  input  logic [31:0]  rm_value,
  input  logic [31:0]  rs_value,
  input  logic         carry_in,
  input  logic         out_ack,
  output logic         in_ack,
  output logic         out_req,
  output logic [31:0]  result,
  output logic         carry_out
);

  logic [n_lanes-1:0]  lane_start;
  logic [n_lanes-1:0]  lane_busy;
  logic [n_lanes-1:0]  lane_done;
  logic [n_lanes-1:0]  lane_take;
  logic [n_lanes-1:0]  lane_carry;
  logic [31:0]         lane_result [n_lanes];

  // Job fields shared by all lanes, valid with lane_start
  shift_type_t         shared_type;
  logic [4:0]          shared_amount;
  logic                shared_use_reg;
  logic [31:0]         shared_rm;
  logic [7:0]          shared_rs_byte;
  logic                shared_carry;

  shift_dispatch u_dispatch (
    .clk            (clk),
    .reset          (reset),
    .in_req         (in_req),
    .op2            (op2),
    .rm_value       (rm_value),
    .rs_value       (rs_value),
    .carry_in       (carry_in),
    .lane_busy      (lane_busy),
    .in_ack         (in_ack),
    .lane_start     (lane_start),
    .shared_type    (shared_type),
    .shared_amount  (shared_amount),
    .shared_use_reg (shared_use_reg),
    .shared_rm      (shared_rm),
    .shared_rs_byte (shared_rs_byte),
    .shared_carry   (shared_carry)
  );

  for (genvar i = 0; i < n_lanes; i++) begin : g_lane
    barrel_shifter_lane u_lane (
      .clk        (clk),
      .reset      (reset),
      .start      (lane_start[i]),
      .shift_type (shared_type),
      .amount     (shared_amount),
      .use_reg    (shared_use_reg),
      .rm         (shared_rm),
      .rs_byte    (shared_rs_byte),
      .carry_in   (shared_carry),
      .take       (lane_take[i]),
      .busy       (lane_busy[i]),
      .done       (lane_done[i]),
      .result     (lane_result[i]),
      .carry_out  (lane_carry[i])
    );
  end

  shift_collector u_collector (
    .clk         (clk),
    .reset       (reset),
    .lane_done   (lane_done),
    .lane_result (lane_result),
    .lane_carry  (lane_carry),
    .out_ack     (out_ack),
    .lane_take   (lane_take),
    .out_req     (out_req),
    .result      (result),
    .carry_out   (carry_out)
  );

endmodule

/* tb/shift_engine_asserts.sv */
`timescale 1ns/10ps

module shift_engine_asserts import shift_pkg::*; (
  input logic                clk,
  input logic                reset,
  input logic                in_req,
  input logic                in_ack,
  input logic                out_req,
  input logic                out_ack,
  input logic [31:0]         result,
  input logic                carry_out,
  input logic [n_lanes-1:0]  lane_start,
  input logic [n_lanes-1:0]  lane_busy,
  input logic [n_lanes-1:0]  lane_done,
  input logic [n_lanes-1:0]  lane_take
);

  // Everything idle once reset has been seen
  a_reset_idle: assert property (@(posedge clk)
    reset |=> !in_ack && !out_req && lane_busy == '0 && lane_done == '0)
    else $error("handshake or lane state not idle after reset");

  // Input side four-phase order
  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(in_ack) |-> $past(in_req))
    else $error("in_ack raised without in_req");

  a_ack_held: assert property (@(posedge clk) disable iff (reset)
    in_ack && in_req |=> in_ack)
    else $error("in_ack dropped while in_req still high");

  // Output side four-phase order
  a_req_held: assert property (@(posedge clk) disable iff (reset)
    out_req && !out_ack |=> out_req && $stable(result) && $stable(carry_out))
    else $error("out_req or its data changed before out_ack");

  a_req_after_release: assert property (@(posedge clk) disable iff (reset)
    $rose(out_req) |-> !$past(out_ack))
    else $error("out_req raised before out_ack fell");

  // Lane bookkeeping
  a_start_free_lane: assert property (@(posedge clk) disable iff (reset)
    (lane_start & lane_busy) == '0 && $onehot0(lane_start))
    else $error("lane_start sent to a busy lane");

  a_take_done_lane: assert property (@(posedge clk) disable iff (reset)
    (lane_take & ~lane_done) == '0 && $onehot0(lane_take))
    else $error("lane_take given to a lane that is not done");

endmodule

bind shift_engine shift_engine_asserts u_asserts (
  .clk        (clk),
  .reset      (reset),
  .in_req     (in_req),
  .in_ack     (in_ack),
  .out_req    (out_req),
  .out_ack    (out_ack),
  .result     (result),
  .carry_out  (carry_out),
  .lane_start (lane_start),
  .lane_busy  (lane_busy),
  .lane_done  (lane_done),
  .lane_take  (lane_take)
);

/* tb/shift_engine_tb.sv */
`timescale 1ns/10ps

module shift_engine_tb import shift_pkg::*; ();

  localparam int n_jobs       = 200;
  localparam int reset_cycles = 10;
  localparam int cycle_limit  = n_jobs * 16 + reset_cycles;

  logic         clk;
  logic         reset;
  logic         in_req;
  op2_t         op2;
  logic [31:0]  rm_value;
  logic [31:0]  rs_value;
  logic         carry_in;
  logic         out_ack;
  logic         in_ack;
  logic         out_req;
  logic [31:0]  result;
  logic         carry_out;

  int           result_errors;
  int           carry_errors;
  int           other_errors;
  int           jobs_done;
  logic [31:0]  job_state;
  logic [31:0]  ack_state;
  logic [31:0]  exp_result_q [$];
  logic         exp_carry_q [$];

  shift_engine UUT (
    .clk       (clk),
    .reset     (reset),
    .in_req    (in_req),
    .op2       (op2),
    .rm_value  (rm_value),
    .rs_value  (rs_value),
    .carry_in  (carry_in),
    .out_ack   (out_ack),
    .in_ack    (in_ack),
    .out_req   (out_req),
    .result    (result),
    .carry_out (carry_out)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [15:0] job_rand();
    job_state = lcg_step(job_state);
    return job_state[31:16];
  endfunction

  function automatic logic [15:0] ack_rand();
    ack_state = lcg_step(ack_state);
    return ack_state[31:16];
  endfunction

  // Reference shifter returning {carry, value}
  function automatic logic [32:0] ref_shift(input logic [1:0] kind, input int amt,
                                            input logic [31:0] rm, input logic cin);
    int          r;
    logic [31:0] fill;
    r    = amt % 32;
    fill = {32{rm[31]}};
    if (amt == 0) begin
      return {cin, rm};
    end
    case (kind)
      2'd0: begin
        if (amt < 32) return {rm[32 - amt], rm << amt};
        if (amt == 32) return {rm[0], 32'd0};
        return {1'b0, 32'd0};
      end
      2'd1: begin
        if (amt < 32) return {rm[amt - 1], rm >> amt};
        if (amt == 32) return {rm[31], 32'd0};
        return {1'b0, 32'd0};
      end
      2'd2: begin
        if (amt < 32) return {rm[amt - 1], (rm >> amt) | (fill << (32 - amt))};
        return {rm[31], fill};
      end
      default: begin
        // Rotate by a multiple of 32 leaves the value alone
        if (r == 0) return {rm[31], rm};
        return {rm[r - 1], (rm >> r) | (rm << (32 - r))};
      end
    endcase
  endfunction

  // Decode the raw operand-2 word the way the ARM encoding defines it
  function automatic logic [32:0] expected_for(input op2_t op, input logic [31:0] rm,
                                               input logic [31:0] rs, input logic cin);
    int          amt;
    logic [11:0] word;
    word = op;
    if (word[4]) begin
      amt = int'(rs[7:0]);
    end else begin
      amt = int'(word[11:7]);
      // LSR #0 and ASR #0 stand for a shift by 32
      if (amt == 0 && (word[6:5] == 2'd1 || word[6:5] == 2'd2)) begin
        amt = 32;
      end
    end
    return ref_shift(word[6:5], amt, rm, cin);
  endfunction

  task automatic make_job(output op2_t op, output logic [31:0] rm, output logic [31:0] rs,
                          output logic cin);
    logic [15:0] r;
    logic [15:0] pick;
    logic [7:0]  rs_byte;
    r         = job_rand();
    pick      = job_rand();
    rm[31:16] = job_rand();
    rm[15:0]  = job_rand();
    rs[31:16] = job_rand();
    rs[15:0]  = job_rand();
    cin       = r[15];
    if (r[2]) begin
      // Spread Rs[7:0] over the edge classes
      case (pick % 8)
        0:       rs_byte = 8'd0;
        1:       rs_byte = 8'd32;
        2:       rs_byte = 8'((1 + (pick >> 3) % 7) * 32);
        3, 4:    rs_byte = 8'(1 + (pick >> 3) % 31);
        default: rs_byte = 8'(33 + (pick >> 3) % 223);
      endcase
      rs[7:0]            = rs_byte;
      op.regs.rs_idx     = r[11:8];
      op.regs.zero       = 1'b0;
      op.regs.shift_type = shift_type_t'(r[1:0]);
      op.regs.form       = 1'b1;
      op.regs.rm_idx     = r[7:4];
    end else begin
      op.imm.amount     = ((pick % 6) == 0) ? 5'd0 : pick[8:4];
      op.imm.shift_type = shift_type_t'(r[1:0]);
      op.imm.form       = 1'b0;
      op.imm.rm_idx     = r[7:4];
    end
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin : reset_gen
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

  initial begin : drive_jobs
    op2_t        op;
    logic [31:0] rm;
    logic [31:0] rs;
    logic        cin;
    logic [32:0] exp;
    int          gap;
    int          hold;
    in_req    = 1'b0;
    op2       = '0;
    rm_value  = '0;
    rs_value  = '0;
    carry_in  = 1'b0;
    job_state = 32'd79058;
    wait (!reset);
    @(negedge clk);
    for (int i = 0; i < n_jobs; i++) begin
      make_job(op, rm, rs, cin);
      exp = expected_for(op, rm, rs, cin);
      exp_result_q.push_back(exp[31:0]);
      exp_carry_q.push_back(exp[32]);
      op2      = op;
      rm_value = rm;
      rs_value = rs;
      carry_in = cin;
      in_req   = 1'b1;
      @(negedge clk);
      while (!in_ack) @(negedge clk);
      // Keep req up a little past the ack now and then
      hold = job_rand() % 3;
      repeat (hold) @(negedge clk);
      in_req = 1'b0;
      @(negedge clk);
      while (in_ack) @(negedge clk);
      gap = ((job_rand() % 4) == 0) ? 1 + job_rand() % 3 : 0;
      repeat (gap) @(negedge clk);
    end
  end

  initial begin : ack_results
    int          delay;
    logic [31:0] exp_r;
    logic        exp_c;
    out_ack   = 1'b0;
    jobs_done = 0;
    result_errors = 0;
    carry_errors  = 0;
    other_errors  = 0;
    ack_state = 32'd79058;
    forever begin
      @(negedge clk);
      if (out_req && !out_ack) begin
        // First result waits long enough for every lane to fill
        if (jobs_done == 0) delay = 40;
        else if ((ack_rand() % 10) == 0) delay = 24 + ack_rand() % 16;
        else delay = ack_rand() % 4;
        repeat (delay) @(negedge clk);
        if (exp_result_q.size() == 0) begin
          $display("result delivered with no job outstanding at %0t", $time);
          other_errors++;
        end else begin
          exp_r = exp_result_q.pop_front();
          exp_c = exp_carry_q.pop_front();
          assert (result === exp_r) else begin
            $display("error %0t result: got %h expected %h", $time, result, exp_r);
            result_errors++;
          end
          assert (carry_out === exp_c) else begin
            $display("error %0t carry_out: got %b expected %b", $time, carry_out, exp_c);
            carry_errors++;
          end
        end
        jobs_done++;
        out_ack = 1'b1;
        @(negedge clk);
        while (out_req) @(negedge clk);
        out_ack = 1'b0;
      end
    end
  end

  initial begin : run_control
    int cycles;
    cycles = 0;
    while (jobs_done < n_jobs && cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (jobs_done < n_jobs) begin
      $display("timeout: not all jobs completed");
      other_errors++;
    end
    repeat (4) @(posedge clk);
    $display("result errors %0d, carry errors %0d, other errors %0d",
             result_errors, carry_errors, other_errors);
    if (result_errors + carry_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* list.f */
src/shift_pkg.sv
src/barrel_shifter_lane.sv
src/shift_dispatch.sv
src/shift_collector.sv
src/shift_engine.sv
tb/shift_engine_asserts.sv
tb/shift_engine_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := shift_engine_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := No errors
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0 --Mdir $(BUILD_DIR)
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The log decides the outcome, the simulator exit code does not
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
